// ==== rtl/uart_pkg.sv ====
// Serial frame definitions: character width, FIFO depth, line states and parity modes
package uart_pkg;

    // Bits per UART character
    localparam int DATA_WIDTH = 8;

    // Width of the data bit index in the serializer and deserializer
    localparam int IDX_WIDTH = $clog2(DATA_WIDTH);

    // Entries per FIFO
    localparam int FIFO_DEPTH = 16;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP
    } line_state_t;

    typedef enum logic [1:0] {
        PAR_NONE,
        PAR_EVEN,
        PAR_ODD
    } parity_mode_t;

endpackage

// ==== rtl/uart_reg_pkg.sv ====
// Register map: APB widths, register offsets, control and status bits, reset values
package uart_reg_pkg;

    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;
    localparam int DIV_WIDTH      = 16;
    localparam int CTRL_WIDTH     = 4;

    typedef enum logic [APB_ADDR_WIDTH-1:0] {
        TX_DATA = 8'h00,
        RX_DATA = 8'h04,
        STATUS  = 8'h08,
        CONTROL = 8'h0C,
        CLK_DIV = 8'h10
    } reg_addr_t;

    // Control bits, the two resets clear themselves
    localparam int CTRL_TX_RESET    = 0;
    localparam int CTRL_RX_RESET    = 1;
    localparam int CTRL_PARITY_EVEN = 2;
    localparam int CTRL_PARITY_ODD  = 3;

    localparam int STAT_RX_EMPTY   = 0;
    localparam int STAT_TX_EMPTY   = 1;
    localparam int STAT_RX_FULL    = 2;
    localparam int STAT_TX_FULL    = 3;
    localparam int STAT_PARITY_ERR = 4;

    localparam logic [CTRL_WIDTH-1:0] CTRL_INIT = '0;
    localparam logic [DIV_WIDTH-1:0]  DIV_INIT  = 16'd16;

endpackage

// ==== rtl/uart_fifo.sv ====
// Synchronous FIFO with valid/ready on both sides and a soft flush
`timescale 1ns/10ps

module uart_fifo #(
    parameter int DEPTH = uart_pkg::FIFO_DEPTH
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            flush_i,
    input  logic [uart_pkg::DATA_WIDTH-1:0] s_data_i,
    input  logic                            s_valid_i,
    output logic                            s_ready_o,
    output logic [uart_pkg::DATA_WIDTH-1:0] m_data_o,
    output logic                            m_valid_o,
    input  logic                            m_ready_i
);
    import uart_pkg::*;

    logic [DATA_WIDTH-1:0]    mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(DEPTH):0]   count_q;
    logic                     push;
    logic                     pop;

    assign s_ready_o = (count_q != ($clog2(DEPTH) + 1)'(DEPTH));
    assign m_valid_o = (count_q != '0);
    assign m_data_o  = mem[rd_ptr_q];
    assign push      = s_valid_i & s_ready_o;
    assign pop       = m_valid_o & m_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= s_data_i;
        end
    end

    // Pointers wrap naturally, DEPTH is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== rtl/uart_tx.sv ====
// UART serializer: start bit, data bits LSB first, optional parity, stop bit
`timescale 1ns/10ps

module uart_tx (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic [uart_reg_pkg::DIV_WIDTH-1:0] clk_div_i,
    input  uart_pkg::parity_mode_t             parity_mode_i,
    input  logic [uart_pkg::DATA_WIDTH-1:0]    data_i,
    input  logic                               valid_i,
    output logic                               ready_o,
    output logic                               uart_tx_o
);
    import uart_pkg::*;
    import uart_reg_pkg::*;

    line_state_t           state_q;
    logic [DIV_WIDTH-1:0]  cnt_q;
    logic [IDX_WIDTH-1:0]  idx_q;
    logic [DATA_WIDTH-1:0] shift_q;
    logic                  par_q;
    logic                  tx_q;
    logic                  bit_end;

    assign bit_end   = (cnt_q == clk_div_i - DIV_WIDTH'(1));
    assign ready_o   = (state_q == IDLE);
    assign uart_tx_o = tx_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            idx_q   <= '0;
            tx_q    <= 1'b1;
        end else begin
            cnt_q <= bit_end ? '0 : cnt_q + DIV_WIDTH'(1);
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (valid_i) begin
                        shift_q <= data_i;
                        par_q   <= (^data_i) ^ (parity_mode_i == PAR_ODD);
                        tx_q    <= 1'b0;
                        state_q <= START;
                    end
                end
                START: begin
                    if (bit_end) begin
                        idx_q   <= '0;
                        tx_q    <= shift_q[0];
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        shift_q <= shift_q >> 1;
                        idx_q   <= idx_q + IDX_WIDTH'(1);
                        if (idx_q == IDX_WIDTH'(DATA_WIDTH - 1)) begin
                            tx_q    <= (parity_mode_i == PAR_NONE) ? 1'b1 : par_q;
                            state_q <= (parity_mode_i == PAR_NONE) ? STOP : PARITY;
                        end else begin
                            tx_q <= shift_q[1];
                        end
                    end
                end
                PARITY: begin
                    if (bit_end) begin
                        tx_q    <= 1'b1;
                        state_q <= STOP;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/uart_rx.sv ====
// UART deserializer with mid-bit sampling and parity check
`timescale 1ns/10ps

module uart_rx (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               flush_i,
    input  logic [uart_reg_pkg::DIV_WIDTH-1:0] clk_div_i,
    input  uart_pkg::parity_mode_t             parity_mode_i,
    input  logic                               uart_rx_i,
    output logic [uart_pkg::DATA_WIDTH-1:0]    data_o,
    output logic                               valid_o,
    output logic                               parity_err_o
);
    import uart_pkg::*;
    import uart_reg_pkg::*;

    line_state_t           state_q;
    logic [DIV_WIDTH-1:0]  cnt_q;
    logic [IDX_WIDTH-1:0]  idx_q;
    logic [DATA_WIDTH-1:0] shift_q;
    logic                  par_acc_q;
    logic                  par_bad_q;
    logic                  rx_meta_q;
    logic                  rx_sync_q;
    logic                  rx_prev_q;
    logic                  bit_end;
    logic                  mid_end;

    // Two-flop synchronizer plus one more stage for edge detection
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_meta_q <= uart_rx_i;
            rx_sync_q <= rx_meta_q;
            rx_prev_q <= rx_sync_q;
        end
    end

    assign bit_end = (cnt_q == clk_div_i - DIV_WIDTH'(1));
    assign mid_end = (cnt_q == (clk_div_i >> 1) - DIV_WIDTH'(1));
    assign data_o  = shift_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            state_q      <= IDLE;
            cnt_q        <= '0;
            idx_q        <= '0;
            par_bad_q    <= 1'b0;
            valid_o      <= 1'b0;
            parity_err_o <= 1'b0;
        end else begin
            valid_o      <= 1'b0;
            parity_err_o <= 1'b0;
            cnt_q        <= bit_end ? '0 : cnt_q + DIV_WIDTH'(1);
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (rx_prev_q && !rx_sync_q) begin
                        state_q <= START;
                    end
                end
                START: begin
                    // Half a bit in, a high line means a glitch
                    if (mid_end) begin
                        cnt_q     <= '0;
                        idx_q     <= '0;
                        par_acc_q <= (parity_mode_i == PAR_ODD);
                        par_bad_q <= 1'b0;
                        state_q   <= rx_sync_q ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_end) begin
                        shift_q   <= {rx_sync_q, shift_q[DATA_WIDTH-1:1]};
                        par_acc_q <= par_acc_q ^ rx_sync_q;
                        idx_q     <= idx_q + IDX_WIDTH'(1);
                        if (idx_q == IDX_WIDTH'(DATA_WIDTH - 1)) begin
                            state_q <= (parity_mode_i == PAR_NONE) ? STOP : PARITY;
                        end
                    end
                end
                PARITY: begin
                    if (bit_end) begin
                        par_bad_q <= par_acc_q ^ rx_sync_q;
                        state_q   <= STOP;
                    end
                end
                STOP: begin
                    if (bit_end) begin
                        valid_o      <= 1'b1;
                        parity_err_o <= par_bad_q;
                        state_q      <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/apb_uart_regs.sv ====
// APB register file with TX push, RX pop, status readback and control outputs
`timescale 1ns/10ps

module apb_uart_regs (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [uart_reg_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [uart_reg_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [uart_reg_pkg::APB_DATA_WIDTH-1:0] prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o,
    input  logic [uart_pkg::DATA_WIDTH-1:0]         rx_data_i,
    input  logic                                    rx_valid_i,
    input  logic                                    tx_ready_i,
    input  logic                                    tx_empty_i,
    input  logic                                    rx_full_i,
    input  logic                                    parity_err_i,
    output logic [uart_pkg::DATA_WIDTH-1:0]         tx_data_o,
    output logic                                    tx_valid_o,
    output logic                                    rx_ready_o,
    output logic                                    tx_flush_o,
    output logic                                    rx_flush_o,
    output uart_pkg::parity_mode_t                  parity_mode_o,
    output logic [uart_reg_pkg::DIV_WIDTH-1:0]      clk_div_o
);
    import uart_pkg::*;
    import uart_reg_pkg::*;

    reg_addr_t                 addr;
    logic                      access;
    logic                      wr_en;
    logic                      mapped;
    logic                      read_only;
    logic [CTRL_WIDTH-1:0]     ctrl_q;
    logic [DIV_WIDTH-1:0]      div_q;
    logic                      parity_err_q;
    logic [APB_DATA_WIDTH-1:0] status;

    assign addr   = reg_addr_t'(paddr_i);
    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (addr)
            TX_DATA, CONTROL, CLK_DIV: read_only = 1'b0;
            RX_DATA, STATUS:           read_only = 1'b1;
            default:                   mapped    = 1'b0;
        endcase
    end

    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~mapped | (pwrite_i & read_only));

    assign tx_data_o  = pwdata_i[DATA_WIDTH-1:0];
    assign tx_valid_o = wr_en & (addr == TX_DATA);
    // Pop only when there is a byte to return
    assign rx_ready_o = access & ~pwrite_i & (addr == RX_DATA) & rx_valid_i;

    always_comb begin
        status                  = '0;
        status[STAT_RX_EMPTY]   = ~rx_valid_i;
        status[STAT_TX_EMPTY]   = tx_empty_i;
        status[STAT_RX_FULL]    = rx_full_i;
        status[STAT_TX_FULL]    = ~tx_ready_i;
        status[STAT_PARITY_ERR] = parity_err_q;
    end

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            case (addr)
                RX_DATA: prdata_o = rx_valid_i ? APB_DATA_WIDTH'(rx_data_i) : '0;
                STATUS:  prdata_o = status;
                CONTROL: prdata_o = APB_DATA_WIDTH'(ctrl_q);
                CLK_DIV: prdata_o = APB_DATA_WIDTH'(div_q);
                default: prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q <= CTRL_INIT;
            div_q  <= DIV_INIT;
        end else begin
            ctrl_q[CTRL_TX_RESET] <= 1'b0;
            ctrl_q[CTRL_RX_RESET] <= 1'b0;
            if (wr_en && addr == CONTROL) begin
                ctrl_q <= pwdata_i[CTRL_WIDTH-1:0];
            end
            if (wr_en && addr == CLK_DIV) begin
                div_q <= pwdata_i[DIV_WIDTH-1:0];
            end
        end
    end

    // Sticky until the RX side is flushed
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || rx_flush_o) begin
            parity_err_q <= 1'b0;
        end else if (parity_err_i) begin
            parity_err_q <= 1'b1;
        end
    end

    assign tx_flush_o = ctrl_q[CTRL_TX_RESET];
    assign rx_flush_o = ctrl_q[CTRL_RX_RESET];
    assign clk_div_o  = div_q;

    // Odd wins if both parity bits are set
    always_comb begin
        if (ctrl_q[CTRL_PARITY_ODD]) begin
            parity_mode_o = PAR_ODD;
        end else if (ctrl_q[CTRL_PARITY_EVEN]) begin
            parity_mode_o = PAR_EVEN;
        end else begin
            parity_mode_o = PAR_NONE;
        end
    end

endmodule

// ==== rtl/apb_uart.sv ====
// APB UART top: register file, TX and RX FIFOs, serializer and deserializer
`timescale 1ns/10ps

module apb_uart (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic                                    psel_i,
    input  logic                                    penable_i,
    input  logic                                    pwrite_i,
    input  logic [uart_reg_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic [uart_reg_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [uart_reg_pkg::APB_DATA_WIDTH-1:0] prdata_o,
    output logic                                    pready_o,
    output logic                                    pslverr_o,
    input  logic                                    uart_rx_i,
    output logic                                    uart_tx_o
);
    import uart_pkg::*;
    import uart_reg_pkg::*;

    logic [DATA_WIDTH-1:0] tx_push_data;
    logic                  tx_push_valid;
    logic                  tx_push_ready;
    logic [DATA_WIDTH-1:0] tx_head_data;
    logic                  tx_head_valid;
    logic                  tx_head_ready;
    logic [DATA_WIDTH-1:0] rx_push_data;
    logic                  rx_push_valid;
    logic                  rx_push_ready;
    logic [DATA_WIDTH-1:0] rx_head_data;
    logic                  rx_head_valid;
    logic                  rx_head_ready;
    logic                  tx_flush;
    logic                  rx_flush;
    logic                  parity_err;
    parity_mode_t          parity_mode;
    logic [DIV_WIDTH-1:0]  clk_div;

    apb_uart_regs u_regs (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .rx_data_i    (rx_head_data),
        .rx_valid_i   (rx_head_valid),
        .tx_ready_i   (tx_push_ready),
        .tx_empty_i   (~tx_head_valid),
        .rx_full_i    (~rx_push_ready),
        .parity_err_i (parity_err),
        .tx_data_o    (tx_push_data),
        .tx_valid_o   (tx_push_valid),
        .rx_ready_o   (rx_head_ready),
        .tx_flush_o   (tx_flush),
        .rx_flush_o   (rx_flush),
        .parity_mode_o(parity_mode),
        .clk_div_o    (clk_div)
    );

    uart_fifo u_tx_fifo (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (tx_flush),
        .s_data_i (tx_push_data),
        .s_valid_i(tx_push_valid),
        .s_ready_o(tx_push_ready),
        .m_data_o (tx_head_data),
        .m_valid_o(tx_head_valid),
        .m_ready_i(tx_head_ready)
    );

    uart_tx u_tx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (tx_flush),
        .clk_div_i    (clk_div),
        .parity_mode_i(parity_mode),
        .data_i       (tx_head_data),
        .valid_i      (tx_head_valid),
        .ready_o      (tx_head_ready),
        .uart_tx_o    (uart_tx_o)
    );

    uart_rx u_rx (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (rx_flush),
        .clk_div_i    (clk_div),
        .parity_mode_i(parity_mode),
        .uart_rx_i    (uart_rx_i),
        .data_o       (rx_push_data),
        .valid_o      (rx_push_valid),
        .parity_err_o (parity_err)
    );

    uart_fifo u_rx_fifo (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .flush_i  (rx_flush),
        .s_data_i (rx_push_data),
        .s_valid_i(rx_push_valid),
        .s_ready_o(rx_push_ready),
        .m_data_o (rx_head_data),
        .m_valid_o(rx_head_valid),
        .m_ready_i(rx_head_ready)
    );

endmodule

// ==== verif/apb_uart_tb.sv ====
// Testbench for the APB UART: APB tasks, loopback, case table, bit-bang driver, watchdog
`timescale 1ns/10ps

module apb_uart_tb;
    import uart_pkg::*;
    import uart_reg_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_CASES   = 19;
    localparam int MAX_DIV     = 10;
    localparam int OVF_DIV     = 8;
    localparam int FRAME_BITS  = 12;
    // Table frames, overflow burst and the idle waits of the later tests
    localparam int TEST_FRAMES = NUM_CASES + FIFO_DEPTH + 2 + 8;
    localparam int TIMEOUT_NS  = TEST_FRAMES * FRAME_BITS * MAX_DIV * CLK_PERIOD + 40000;

    typedef struct packed {
        parity_mode_t          mode;
        logic [DIV_WIDTH-1:0]  div;
        logic [DATA_WIDTH-1:0] data;
        logic                  corrupt;
        logic                  loop;
        logic                  last;
        logic [DATA_WIDTH-1:0] exp_data;
        logic                  exp_err;
    } case_t;

    logic                      clk;
    logic                      rst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      uart_rx;
    logic                      uart_tx;
    logic                      loop_en;
    logic                      bb_line;
    case_t                     cases [NUM_CASES];
    int                        errors;
    int                        checks;

    assign uart_rx = loop_en ? uart_tx : bb_line;

    apb_uart u_dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .psel_i   (psel),
        .penable_i(penable),
        .pwrite_i (pwrite),
        .paddr_i  (paddr),
        .pwdata_i (pwdata),
        .prdata_o (prdata),
        .pready_o (pready),
        .pslverr_o(pslverr),
        .uart_rx_i(uart_rx),
        .uart_tx_o(uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

    // Even parity makes the number of ones even, odd makes it odd
    function automatic logic parity_bit(logic [7:0] data, parity_mode_t mode);
        return (mode == PAR_ODD) ? ~(^data) : ^data;
    endfunction

    function automatic logic [31:0] ctrl_word(parity_mode_t mode);
        logic [31:0] w;
        w = '0;
        if (mode == PAR_EVEN) begin
            w[CTRL_PARITY_EVEN] = 1'b1;
        end else if (mode == PAR_ODD) begin
            w[CTRL_PARITY_ODD] = 1'b1;
        end
        return w;
    endfunction

    function automatic void build_cases();
        logic [7:0] rnd [6];
        for (int k = 0; k < 6; k++) begin
            rnd[k] = 8'($urandom);
        end
        // mode, div, data, corrupt, loop, last, expected byte, expected parity error
        cases[0]  = '{PAR_NONE, 16'd6, 8'h55, 1'b0, 1'b1, 1'b0, 8'h55, 1'b0};
        cases[1]  = '{PAR_NONE, 16'd6, 8'hA3, 1'b0, 1'b1, 1'b0, 8'hA3, 1'b0};
        cases[2]  = '{PAR_NONE, 16'd6, rnd[0], 1'b0, 1'b1, 1'b1, rnd[0], 1'b0};
        cases[3]  = '{PAR_EVEN, 16'd6, 8'h01, 1'b0, 1'b1, 1'b0, 8'h01, 1'b0};
        cases[4]  = '{PAR_EVEN, 16'd6, 8'hFE, 1'b0, 1'b1, 1'b0, 8'hFE, 1'b0};
        cases[5]  = '{PAR_EVEN, 16'd6, rnd[1], 1'b0, 1'b1, 1'b1, rnd[1], 1'b0};
        cases[6]  = '{PAR_ODD, 16'd10, 8'h00, 1'b0, 1'b1, 1'b0, 8'h00, 1'b0};
        cases[7]  = '{PAR_ODD, 16'd10, 8'h7F, 1'b0, 1'b1, 1'b0, 8'h7F, 1'b0};
        cases[8]  = '{PAR_ODD, 16'd10, rnd[2], 1'b0, 1'b1, 1'b1, rnd[2], 1'b0};
        cases[9]  = '{PAR_NONE, 16'd10, rnd[3], 1'b0, 1'b1, 1'b0, rnd[3], 1'b0};
        cases[10] = '{PAR_NONE, 16'd10, 8'hC4, 1'b0, 1'b1, 1'b1, 8'hC4, 1'b0};
        cases[11] = '{PAR_EVEN, 16'd10, rnd[4], 1'b0, 1'b1, 1'b0, rnd[4], 1'b0};
        cases[12] = '{PAR_EVEN, 16'd10, 8'h96, 1'b0, 1'b1, 1'b1, 8'h96, 1'b0};
        cases[13] = '{PAR_ODD, 16'd6, rnd[5], 1'b0, 1'b1, 1'b0, rnd[5], 1'b0};
        cases[14] = '{PAR_ODD, 16'd6, 8'h3A, 1'b0, 1'b1, 1'b1, 8'h3A, 1'b0};
        // Bit-banged frames, correct parity first, then inverted
        cases[15] = '{PAR_EVEN, 16'd6, 8'h5B, 1'b0, 1'b0, 1'b1, 8'h5B, 1'b0};
        cases[16] = '{PAR_EVEN, 16'd6, 8'h5B, 1'b1, 1'b0, 1'b1, 8'h5B, 1'b1};
        cases[17] = '{PAR_ODD, 16'd10, 8'hE1, 1'b0, 1'b0, 1'b1, 8'hE1, 1'b0};
        cases[18] = '{PAR_ODD, 16'd10, 8'hE1, 1'b1, 1'b0, 1'b1, 8'hE1, 1'b1};
    endfunction

    task automatic check_bus(input logic [7:0] addr, input logic exp_err);
        checks++;
        if (pslverr !== exp_err) begin
            $display("error pslverr at 0x%02h: got 0x%h expected 0x%h", addr, pslverr, exp_err);
            errors++;
        end
        if (pready !== 1'b1) begin
            $display("error pready at 0x%02h: got 0x%h expected 0x1", addr, pready);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        check_bus(addr, exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        data = prdata;
        check_bus(addr, exp_err);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] rd;
        apb_read(addr, rd, 1'b0);
        checks++;
        if (rd !== exp) begin
            $display("error %s: got 0x%08h expected 0x%08h", name, rd, exp);
            errors++;
        end
    endtask

    task automatic check_status_bit(input string name, input int pos, input logic exp);
        logic [31:0] st;
        apb_read(STATUS, st, 1'b0);
        checks++;
        if (st[pos] !== exp) begin
            $display("error %s: got 0x%h expected 0x%h", name, st[pos], exp);
            errors++;
        end
    endtask

    task automatic wait_rx_byte();
        logic [31:0] st;
        st = '1;
        while (st[STAT_RX_EMPTY]) begin
            apb_read(STATUS, st, 1'b0);
        end
    endtask

    task automatic send_frame(input logic [7:0] data, input parity_mode_t mode,
                              input logic [15:0] div, input logic corrupt);
        logic [10:0] bits;
        int          nbits;
        // Start bit in bit 0, then data LSB first, parity and stop
        bits  = {1'b1, parity_bit(data, mode) ^ corrupt, data, 1'b0};
        nbits = 11;
        if (mode == PAR_NONE) begin
            bits  = {2'b11, data, 1'b0};
            nbits = 10;
        end
        for (int b = 0; b < nbits; b++) begin
            @(posedge clk);
            #1;
            bb_line = bits[b];
            repeat (div - 1) @(posedge clk);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] w;
        logic [7:0]  exp_data_q [$];
        logic        exp_err_q [$];
        logic        first;
        int          wait_cycles;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        loop_en = 1'b1;
        bb_line = 1'b1;
        errors  = 0;
        checks  = 0;
        void'($urandom(32'h2353));
        build_cases();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset values
        check_reg("STATUS", STATUS, (32'h1 << STAT_RX_EMPTY) | (32'h1 << STAT_TX_EMPTY));
        check_reg("CLK_DIV", CLK_DIV, 32'(DIV_INIT));
        check_reg("CONTROL", CONTROL, 32'h0);
        checks++;
        if (uart_tx !== 1'b1) begin
            $display("error uart_tx_o: got 0x%h expected 0x1", uart_tx);
            errors++;
        end

        // Loopback groups and bit-banged parity frames
        first = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            if (first) begin
                apb_write(CONTROL, ctrl_word(cases[i].mode), 1'b0);
                apb_write(CLK_DIV, 32'(cases[i].div), 1'b0);
            end
            first   = cases[i].last;
            loop_en = cases[i].loop;
            if (cases[i].loop) begin
                apb_write(TX_DATA, 32'(cases[i].data), 1'b0);
            end else begin
                send_frame(cases[i].data, cases[i].mode, cases[i].div, cases[i].corrupt);
            end
            exp_data_q.push_back(cases[i].exp_data);
            exp_err_q.push_back(cases[i].exp_err);
            if (cases[i].last) begin
                while (exp_data_q.size() > 0) begin
                    wait_rx_byte();
                    check_reg("RX_DATA", RX_DATA, 32'(exp_data_q.pop_front()));
                    if (exp_err_q.pop_front()) begin
                        check_status_bit("STATUS parity_err", STAT_PARITY_ERR, 1'b1);
                        w                = ctrl_word(cases[i].mode);
                        w[CTRL_RX_RESET] = 1'b1;
                        apb_write(CONTROL, w, 1'b0);
                    end
                    check_status_bit("STATUS parity_err", STAT_PARITY_ERR, 1'b0);
                end
            end
        end

        // Overflow: one byte in the transmitter, a full FIFO, the last byte dropped
        loop_en = 1'b1;
        apb_write(CONTROL, 32'h0, 1'b0);
        apb_write(CLK_DIV, 32'(OVF_DIV), 1'b0);
        for (int k = 0; k < FIFO_DEPTH + 2; k++) begin
            apb_write(TX_DATA, 32'(8'hA0 + k), 1'b0);
        end
        check_status_bit("STATUS tx_full", STAT_TX_FULL, 1'b1);
        for (int k = 0; k < FIFO_DEPTH + 1; k++) begin
            wait_rx_byte();
            check_reg("RX_DATA", RX_DATA, 32'(8'hA0 + k));
        end
        repeat (2 * FRAME_BITS * OVF_DIV) @(posedge clk);
        check_status_bit("STATUS rx_empty", STAT_RX_EMPTY, 1'b1);
        check_status_bit("STATUS tx_empty", STAT_TX_EMPTY, 1'b1);

        // Soft reset with bytes queued, the receiver is mid-frame as well
        apb_write(TX_DATA, 32'h0000_0011, 1'b0);
        wait_cycles = 0;
        while (uart_tx === 1'b1 && wait_cycles < 3) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        checks++;
        if (uart_tx !== 1'b0) begin
            $display("No start bit on uart_tx_o within 3 cycles of the TX_DATA write");
            errors++;
        end
        apb_write(TX_DATA, 32'h0000_0022, 1'b0);
        apb_write(TX_DATA, 32'h0000_0033, 1'b0);
        w                = '0;
        w[CTRL_TX_RESET] = 1'b1;
        w[CTRL_RX_RESET] = 1'b1;
        apb_write(CONTROL, w, 1'b0);
        check_status_bit("STATUS tx_empty", STAT_TX_EMPTY, 1'b1);
        checks++;
        if (uart_tx !== 1'b1) begin
            $display("error uart_tx_o: got 0x%h expected 0x1", uart_tx);
            errors++;
        end
        repeat (3 * FRAME_BITS * OVF_DIV) @(posedge clk);
        check_status_bit("STATUS rx_empty", STAT_RX_EMPTY, 1'b1);
        check_reg("CONTROL", CONTROL, 32'h0);

        // Bus errors leave every register as it was
        apb_read(8'h14, rd, 1'b1);
        apb_write(8'h20, 32'hFFFF_FFFF, 1'b1);
        apb_write(STATUS, 32'hFFFF_FFFF, 1'b1);
        apb_write(RX_DATA, 32'h0000_005A, 1'b1);
        check_reg("CONTROL", CONTROL, 32'h0);
        check_reg("CLK_DIV", CLK_DIV, 32'(OVF_DIV));
        check_reg("STATUS", STATUS, (32'h1 << STAT_RX_EMPTY) | (32'h1 << STAT_TX_EMPTY));

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/uart_pkg.sv
rtl/uart_reg_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/apb_uart_regs.sv
rtl/apb_uart.sv
verif/apb_uart_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the APB UART testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/10ps --top-module apb_uart_tb -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vapb_uart_tb); then
    echo "$out"
    echo "Simulation exited with a failing status"
    exit 1
fi
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
